//--- common/rv32i_types.sv
package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg_idx;

    // alu operations, the encoding is internal to the back end.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // source of the writeback value.
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_PC4  = 2'd2,
        WB_IMM  = 2'd3
    } wb_sel_t;

endpackage

//--- common/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    localparam int CW_WIDTH = 16;

    typedef logic [CW_WIDTH-1:0] rv32i_control_word;

    // control word field positions.
    localparam int CW_ALU_OP_LSB   = 0;   // 4 bits.
    localparam int CW_REG_WRITE    = 4;
    localparam int CW_MEM_READ     = 5;
    localparam int CW_MEM_WRITE    = 6;
    localparam int CW_MEM_SIZE_LSB = 7;   // 2 bits.
    localparam int CW_MEM_UNSIGNED = 9;
    localparam int CW_BRANCH       = 10;
    localparam int CW_JUMP         = 11;
    localparam int CW_JUMP_REG     = 12;  // target from rs1.
    localparam int CW_WB_SEL_LSB   = 13;  // 2 bits.
    localparam int CW_ALU_IMM      = 15;  // immediate as operand b.

    // mem_size field values match the low funct3 bits.
    localparam logic [1:0] MEM_SIZE_B = 2'b00;
    localparam logic [1:0] MEM_SIZE_H = 2'b01;
    localparam logic [1:0] MEM_SIZE_W = 2'b10;

    // branch conditions use the rv32i funct3 codes.
    typedef logic [2:0] br_funct;

    localparam br_funct BR_BEQ  = 3'b000;
    localparam br_funct BR_BNE  = 3'b001;
    localparam br_funct BR_BLT  = 3'b100;
    localparam br_funct BR_BGE  = 3'b101;
    localparam br_funct BR_BLTU = 3'b110;
    localparam br_funct BR_BGEU = 3'b111;

    typedef enum logic [1:0] {
        RUN       = 2'd0,
        LOAD_WAIT = 2'd1,
        FLUSH     = 2'd2
    } pipe_state_t;

endpackage

//--- common/ex_mem_if.sv
`timescale 1ns/1ps

interface ex_mem_if;
    import rv32i_types::*;
    import pipe_ctrl_pkg::*;

    logic              valid;
    rv32i_word         pc;
    rv32i_word         alu_out;
    rv32i_word         rs2_data;
    rv32i_word         imm;
    rv32i_control_word ctrl;
    rv32i_reg_idx      rd;
    logic              br_en;
    rv32i_word         target;

    modport producer (
        output valid,
        output pc,
        output alu_out,
        output rs2_data,
        output imm,
        output ctrl,
        output rd,
        output br_en,
        output target
    );

    modport consumer (
        input valid,
        input pc,
        input alu_out,
        input rs2_data,
        input imm,
        input ctrl,
        input rd,
        input br_en,
        input target
    );

endinterface

//--- rtl/execute/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  rv32i_types::rv32i_word           pc_i,
    input  rv32i_types::rv32i_word           rs1_data_i,
    input  rv32i_types::rv32i_word           rs2_data_i,
    input  rv32i_types::rv32i_word           imm_i,
    input  pipe_ctrl_pkg::rv32i_control_word ctrl_word_i,
    input  pipe_ctrl_pkg::br_funct           br_funct_i,
    output rv32i_types::rv32i_word           alu_out_o,
    output logic                             br_en_o,
    output rv32i_types::rv32i_word           target_o
);
    import rv32i_types::*;
    import pipe_ctrl_pkg::*;

    alu_op_t   alu_op;
    logic      use_imm;
    rv32i_word op_a;
    rv32i_word op_b;
    logic [4:0] shamt;
    rv32i_word jalr_sum;

    assign alu_op = alu_op_t'(ctrl_word_i[CW_ALU_OP_LSB +: 4]);

    // loads and stores form an address, branches compare registers.
    assign use_imm = !ctrl_word_i[CW_BRANCH] &&
                     (ctrl_word_i[CW_ALU_IMM] || ctrl_word_i[CW_MEM_READ] ||
                      ctrl_word_i[CW_MEM_WRITE]);

    assign op_a  = rs1_data_i;
    assign op_b  = use_imm ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_out_o = op_a + op_b;
            ALU_SUB:  alu_out_o = op_a - op_b;
            ALU_SLL:  alu_out_o = op_a << shamt;
            ALU_SLT:  alu_out_o = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out_o = {31'b0, op_a < op_b};
            ALU_XOR:  alu_out_o = op_a ^ op_b;
            ALU_SRL:  alu_out_o = op_a >> shamt;
            ALU_SRA:  alu_out_o = $signed(op_a) >>> shamt;
            ALU_OR:   alu_out_o = op_a | op_b;
            ALU_AND:  alu_out_o = op_a & op_b;
            default:  alu_out_o = op_a + op_b;
        endcase
    end

    // branch compare always uses both registers.
    always_comb begin
        case (br_funct_i)
            BR_BEQ:  br_en_o = (rs1_data_i == rs2_data_i);
            BR_BNE:  br_en_o = (rs1_data_i != rs2_data_i);
            BR_BLT:  br_en_o = ($signed(rs1_data_i) < $signed(rs2_data_i));
            BR_BGE:  br_en_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            BR_BLTU: br_en_o = (rs1_data_i < rs2_data_i);
            BR_BGEU: br_en_o = (rs1_data_i >= rs2_data_i);
            default: br_en_o = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_data_i + imm_i;

    // jalr clears bit 0 of the sum.
    assign target_o = ctrl_word_i[CW_JUMP_REG] ? {jalr_sum[31:1], 1'b0} : pc_i + imm_i;

endmodule

//--- rtl/ex_mem.sv
`timescale 1ns/1ps

module ex_mem (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_i,
    input  logic                             flush_i,
    input  logic                             valid_i,
    input  rv32i_types::rv32i_word           pc_i,
    input  rv32i_types::rv32i_word           alu_out_i,
    input  rv32i_types::rv32i_word           rs2_data_i,
    input  rv32i_types::rv32i_word           imm_i,
    input  pipe_ctrl_pkg::rv32i_control_word ctrl_word_i,
    input  rv32i_types::rv32i_reg_idx        rd_i,
    input  logic                             br_en_i,
    input  rv32i_types::rv32i_word           target_i,
    ex_mem_if.producer                       stage
);

    // valid and control word carry the entry state.
    always_ff @(posedge clk) begin
        if (rst) begin
            stage.valid <= 1'b0;
            stage.ctrl  <= '0;
        end else if (load_i) begin
            stage.valid <= valid_i && !flush_i;  // squashed behind a redirect.
            stage.ctrl  <= ctrl_word_i;
        end
    end

    // payload follows the same load, held otherwise.
    always_ff @(posedge clk) begin
        if (load_i) begin
            stage.pc       <= pc_i;
            stage.alu_out  <= alu_out_i;
            stage.rs2_data <= rs2_data_i;
            stage.imm      <= imm_i;
            stage.rd       <= rd_i;
            stage.br_en    <= br_en_i;
            stage.target   <= target_i;
        end
    end

endmodule

//--- rtl/memory/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int MEM_WORDS = 256
) (
    input  logic                      clk,
    input  logic                      rst,
    ex_mem_if.consumer                stage,
    output logic                      wb_valid_o,
    output rv32i_types::rv32i_reg_idx wb_rd_o,
    output rv32i_types::rv32i_word    wb_data_o
);
    import rv32i_types::*;
    import pipe_ctrl_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    rv32i_word        mem [MEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       byte_off;
    logic [1:0]       mem_size;
    logic [3:0]       byte_en;
    rv32i_word        st_data;
    rv32i_word        rd_word_q;
    logic             rd_done_q;
    logic             is_load;
    rv32i_word        ld_shift;
    rv32i_word        ld_data;
    wb_sel_t          wb_sel;

    assign word_idx = stage.alu_out[IDX_W+1:2];
    assign byte_off = stage.alu_out[1:0];
    assign mem_size = stage.ctrl[CW_MEM_SIZE_LSB +: 2];
    assign is_load  = stage.valid && stage.ctrl[CW_MEM_READ];
    assign wb_sel   = wb_sel_t'(stage.ctrl[CW_WB_SEL_LSB +: 2]);

    // store lanes, data replicated so the enables pick the byte.
    always_comb begin
        case (mem_size)
            MEM_SIZE_B: begin
                byte_en = 4'b0001 << byte_off;
                st_data = {4{stage.rs2_data[7:0]}};
            end
            MEM_SIZE_H: begin
                byte_en = 4'b0011 << {byte_off[1], 1'b0};
                st_data = {2{stage.rs2_data[15:0]}};
            end
            MEM_SIZE_W: begin
                byte_en = 4'b1111;
                st_data = stage.rs2_data;
            end
            default: begin
                byte_en = 4'b0000;
                st_data = stage.rs2_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (stage.valid && stage.ctrl[CW_MEM_WRITE]) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= st_data[8*b +: 8];
                end
            end
        end
        rd_word_q <= mem[word_idx];  // read every cycle.
    end

    // high in the second cycle of a held load.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_done_q <= 1'b0;
        end else begin
            rd_done_q <= is_load && !rd_done_q;
        end
    end

    // the entry is held, so the address bits still match the read.
    assign ld_shift = rd_word_q >> {byte_off, 3'b000};

    always_comb begin
        case (mem_size)
            MEM_SIZE_B: ld_data = stage.ctrl[CW_MEM_UNSIGNED] ? {24'b0, ld_shift[7:0]}
                                                             : {{24{ld_shift[7]}}, ld_shift[7:0]};
            MEM_SIZE_H: ld_data = stage.ctrl[CW_MEM_UNSIGNED] ? {16'b0, ld_shift[15:0]}
                                                             : {{16{ld_shift[15]}}, ld_shift[15:0]};
            default:    ld_data = rd_word_q;
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_ALU:  wb_data_o = stage.alu_out;
            WB_LOAD: wb_data_o = ld_data;
            WB_PC4:  wb_data_o = stage.pc + 32'd4;
            WB_IMM:  wb_data_o = stage.imm;
            default: wb_data_o = stage.alu_out;
        endcase
    end

    assign wb_rd_o    = stage.rd;
    assign wb_valid_o = stage.valid && stage.ctrl[CW_REG_WRITE] && (stage.rd != '0) &&
                        (!stage.ctrl[CW_MEM_READ] || rd_done_q);

endmodule

//--- rtl/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    ex_mem_if.consumer             stage,
    output logic                   load_o,
    output logic                   flush_o,
    output logic                   stall_o,
    output logic                   redirect_o,
    output rv32i_types::rv32i_word redirect_pc_o
);
    import pipe_ctrl_pkg::*;

    pipe_state_t state;
    pipe_state_t state_q;
    logic        taken;

    assign taken = stage.ctrl[CW_JUMP] || (stage.ctrl[CW_BRANCH] && stage.br_en);

    // state of the current cycle, decoded from the entry in EX/MEM.
    // state_q remembers a load that has already waited once.
    always_comb begin
        state = RUN;
        if (stage.valid) begin
            if (stage.ctrl[CW_MEM_READ] && state_q != LOAD_WAIT) begin
                state = LOAD_WAIT;
            end else if (taken) begin
                state = FLUSH;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= RUN;
        end else begin
            state_q <= state;
        end
    end

    always_comb begin
        load_o     = 1'b1;
        flush_o    = 1'b0;
        stall_o    = 1'b0;
        redirect_o = 1'b0;
        case (state)
            LOAD_WAIT: begin
                load_o  = 1'b0;  // hold the load one more cycle.
                stall_o = 1'b1;
            end
            FLUSH: begin
                flush_o    = 1'b1;  // squash the wrong-path issue.
                redirect_o = 1'b1;
            end
            default: begin
                load_o = 1'b1;
            end
        endcase
    end

    assign redirect_pc_o = stage.target;

endmodule

//--- rtl/rv32i_backend.sv
`timescale 1ns/1ps

module rv32i_backend #(
    parameter int MEM_WORDS = 256
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             issue_valid_i,
    input  rv32i_types::rv32i_word           pc_i,
    input  rv32i_types::rv32i_word           rs1_data_i,
    input  rv32i_types::rv32i_word           rs2_data_i,
    input  rv32i_types::rv32i_word           imm_i,
    input  pipe_ctrl_pkg::rv32i_control_word ctrl_word_i,
    input  pipe_ctrl_pkg::br_funct           br_funct_i,
    input  rv32i_types::rv32i_reg_idx        rd_i,
    output logic                             stall_o,
    output logic                             redirect_o,
    output rv32i_types::rv32i_word           redirect_pc_o,
    output logic                             wb_valid_o,
    output rv32i_types::rv32i_reg_idx        wb_rd_o,
    output rv32i_types::rv32i_word           wb_data_o
);
    import rv32i_types::*;

    rv32i_word alu_out;
    rv32i_word target;
    logic      br_en;
    logic      load;
    logic      flush;

    ex_mem_if ex_mem_bus ();

    ex_stage ex_stage_inst (
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .imm_i       (imm_i),
        .ctrl_word_i (ctrl_word_i),
        .br_funct_i  (br_funct_i),
        .alu_out_o   (alu_out),
        .br_en_o     (br_en),
        .target_o    (target)
    );

    ex_mem ex_mem_inst (
        .clk         (clk),
        .rst         (rst),
        .load_i      (load),
        .flush_i     (flush),
        .valid_i     (issue_valid_i),
        .pc_i        (pc_i),
        .alu_out_i   (alu_out),
        .rs2_data_i  (rs2_data_i),
        .imm_i       (imm_i),
        .ctrl_word_i (ctrl_word_i),
        .rd_i        (rd_i),
        .br_en_i     (br_en),
        .target_i    (target),
        .stage       (ex_mem_bus.producer)
    );

    mem_stage #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .stage      (ex_mem_bus.consumer),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

    pipe_ctrl pipe_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .stage         (ex_mem_bus.consumer),
        .load_o        (load),
        .flush_o       (flush),
        .stall_o       (stall_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

//--- tb/rv32i_backend_chk.sv
`timescale 1ns/1ps

module rv32i_backend_chk (
    input logic clk,
    input logic rst,
    input logic stall_i,
    input logic redirect_i,
    input logic wb_valid_i
);

    // a load holds the entry for one cycle only.
    stall_one_cycle: assert property (@(posedge clk) disable iff (rst) stall_i |=> !stall_i)
        else $error("stall_o was high for two consecutive cycles");

    redirect_one_cycle: assert property (
        @(posedge clk) disable iff (rst) redirect_i |=> !redirect_i)
        else $error("redirect_o lasted longer than one cycle");

    // outputs are cleared by the first reset edge.
    no_wb_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !wb_valid_i)
        else $error("wb_valid_o was high during reset");

endmodule

//--- tb/tb_rv32i_backend.sv
`timescale 1ns/1ps

module tb_rv32i_backend;
    import rv32i_types::*;
    import pipe_ctrl_pkg::*;

    localparam int MEM_WORDS  = 256;
    localparam int IDX_W      = $clog2(MEM_WORDS);
    localparam int NUM_RANDOM = 600;
    localparam br_funct CONDS [6] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

    logic              clk;
    logic              rst;
    logic              issue_valid;
    rv32i_word         pc, rs1_data, rs2_data, imm;
    rv32i_control_word ctrl_word;
    br_funct           br_cond;
    rv32i_reg_idx      rd;
    logic              stall, redirect, wb_valid;
    rv32i_word         redirect_pc, wb_data;
    rv32i_reg_idx      wb_rd;

    integer            seed;
    rv32i_word         model_mem [MEM_WORDS];
    logic              e_valid, e_wait;  // model of the EX/MEM entry.
    rv32i_word         e_pc, e_rs1, e_rs2, e_imm;
    rv32i_control_word e_ctrl;
    br_funct           e_cond;
    rv32i_reg_idx      e_rd;

    rv32i_backend #(
        .MEM_WORDS (MEM_WORDS)
    ) rv32i_backend_inst (
        .clk           (clk),
        .rst           (rst),
        .issue_valid_i (issue_valid),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .imm_i         (imm),
        .ctrl_word_i   (ctrl_word),
        .br_funct_i    (br_cond),
        .rd_i          (rd),
        .stall_o       (stall),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    bind rv32i_backend rv32i_backend_chk rv32i_backend_chk_inst (
        .clk        (clk),
        .rst        (rst),
        .stall_i    (stall_o),
        .redirect_i (redirect_o),
        .wb_valid_i (wb_valid_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic rv32i_word alu_model(input alu_op_t op, input rv32i_word a,
                                            input rv32i_word b);
        case (op)
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return rv32i_word'($signed(a) >>> b[4:0]);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return a + b;
        endcase
    endfunction

    function automatic logic branch_taken(input br_funct cond, input rv32i_word a,
                                          input rv32i_word b);
        case (cond)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic rv32i_word load_value(input rv32i_word word, input logic [1:0] off,
                                             input logic [1:0] size, input logic uns);
        rv32i_word v;
        v = word >> (8 * off);
        if (size == MEM_SIZE_B) return uns ? {24'b0, v[7:0]} : {{24{v[7]}}, v[7:0]};
        if (size == MEM_SIZE_H) return uns ? {16'b0, v[15:0]} : {{16{v[15]}}, v[15:0]};
        return word;
    endfunction

    function automatic rv32i_word store_merge(input rv32i_word old, input rv32i_word data,
                                              input logic [1:0] off, input logic [1:0] size);
        rv32i_word w;
        w = old;
        case (size)
            MEM_SIZE_B: w[8*off +: 8] = data[7:0];
            MEM_SIZE_H: w[16*off[1] +: 16] = data[15:0];
            default:    w = data;
        endcase
        return w;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error at %0t: %s is %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_wb(input rv32i_reg_idx exp_rd, input rv32i_word exp_data);
        if (wb_rd !== exp_rd || wb_data !== exp_data) begin
            stop_with_failure($sformatf("Error at %0t: writeback x%0d = %h, expected x%0d = %h",
                                        $time, wb_rd, wb_data, exp_rd, exp_data));
        end
    endtask

    task automatic check_redirect(input rv32i_word exp_pc);
        if (redirect_pc !== exp_pc) begin
            stop_with_failure($sformatf("Error at %0t: redirect_pc_o is %h, expected %h",
                                        $time, redirect_pc, exp_pc));
        end
    endtask

    // checks one cycle against the model, then steps the model at the edge.
    task automatic end_cycle();
        logic             ld;
        logic             exp_stall;
        logic             exp_redirect;
        logic             exp_wb;
        logic [1:0]       size;
        logic [IDX_W-1:0] widx;
        rv32i_word        addr;
        rv32i_word        exp_data;
        ld           = e_valid && e_ctrl[CW_MEM_READ];
        size         = e_ctrl[CW_MEM_SIZE_LSB +: 2];
        addr         = e_rs1 + e_imm;
        widx         = addr[IDX_W+1:2];
        exp_stall    = ld && !e_wait;
        exp_redirect = e_valid && (e_ctrl[CW_JUMP] ||
                       (e_ctrl[CW_BRANCH] && branch_taken(e_cond, e_rs1, e_rs2)));
        exp_wb       = e_valid && e_ctrl[CW_REG_WRITE] && e_rd != 5'd0 && (!ld || e_wait);
        case (wb_sel_t'(e_ctrl[CW_WB_SEL_LSB +: 2]))
            WB_LOAD: exp_data = load_value(model_mem[widx], addr[1:0], size,
                                           e_ctrl[CW_MEM_UNSIGNED]);
            WB_PC4:  exp_data = e_pc + 32'd4;
            WB_IMM:  exp_data = e_imm;
            default: exp_data = alu_model(alu_op_t'(e_ctrl[CW_ALU_OP_LSB +: 4]), e_rs1,
                                          e_ctrl[CW_ALU_IMM] ? e_imm : e_rs2);
        endcase
        @(negedge clk);
        check_level("stall_o", stall, exp_stall);
        check_level("redirect_o", redirect, exp_redirect);
        check_level("wb_valid_o", wb_valid, exp_wb);
        if (exp_wb) check_wb(e_rd, exp_data);
        if (exp_redirect) check_redirect(e_ctrl[CW_JUMP_REG] ? (addr & 32'hffff_fffe)
                                                             : e_pc + e_imm);
        @(posedge clk);
        if (e_valid && e_ctrl[CW_MEM_WRITE]) begin
            model_mem[widx] = store_merge(model_mem[widx], e_rs2, addr[1:0], size);
        end
        if (exp_stall) begin
            e_wait = 1'b1;  // entry held for the read.
        end else begin
            e_wait  = 1'b0;
            e_valid = issue_valid && !exp_redirect;  // squashed behind a redirect.
            e_pc    = pc;
            e_rs1   = rs1_data;
            e_rs2   = rs2_data;
            e_imm   = imm;
            e_ctrl  = ctrl_word;
            e_cond  = br_cond;
            e_rd    = rd;
        end
        #2;
    endtask

    // presents the current inputs until a cycle without stall takes them.
    task automatic send_instr();
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            accepted = !(e_valid && e_ctrl[CW_MEM_READ] && !e_wait);
            end_cycle();
        end
    endtask

    task automatic fill_word(input int i);
        rv32i_control_word cw;
        cw                       = '0;
        cw[CW_MEM_WRITE]         = 1'b1;
        cw[CW_MEM_SIZE_LSB +: 2] = MEM_SIZE_W;
        issue_valid = 1'b1;
        rs1_data    = $random(seed);
        imm         = (rv32i_word'(i) << 2) - rs1_data;
        rs2_data    = (rv32i_word'(i) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
        ctrl_word   = cw;
        rd          = '0;
    endtask

    task automatic pick_instr();
        int                r;
        int                kind;
        logic [1:0]        size;
        logic [2:0]        cidx;
        rv32i_word         addr;
        rv32i_control_word cw;
        r           = $random(seed);
        kind        = int'(r[7:4]);
        size        = (r[14:13] == 2'b11) ? MEM_SIZE_W : r[14:13];
        addr        = rv32i_word'({$random(seed)} % MEM_WORDS) << 2;
        addr[1:0]   = (size == MEM_SIZE_B) ? r[16:15] : {r[16] & (size == MEM_SIZE_H), 1'b0};
        cidx        = 3'({$random(seed)} % 6);
        issue_valid = (kind < 14);
        pc          = {$random(seed)} & 32'hffff_fffc;
        rs1_data    = $random(seed);
        rs2_data    = r[3] ? rs1_data : $random(seed);  // equal operands now and then.
        imm         = $random(seed);
        rd          = r[12:8];
        br_cond     = CONDS[cidx];
        cw          = '0;
        cw[CW_REG_WRITE] = 1'b1;
        case (kind)
            0, 1, 2, 3, 4, 5: begin
                cw[CW_ALU_OP_LSB +: 4] = 4'({$random(seed)} % 10);
                cw[CW_ALU_IMM]         = (kind > 2);
            end
            6, 7: begin
                cw[CW_MEM_READ]          = 1'b1;
                cw[CW_MEM_SIZE_LSB +: 2] = size;
                cw[CW_MEM_UNSIGNED]      = r[17];
                cw[CW_WB_SEL_LSB +: 2]   = WB_LOAD;
                imm                      = addr - rs1_data;
            end
            8, 9: begin
                cw[CW_REG_WRITE]         = 1'b0;
                cw[CW_MEM_WRITE]         = 1'b1;
                cw[CW_MEM_SIZE_LSB +: 2] = size;
                imm                      = addr - rs1_data;
            end
            10, 11: begin
                cw[CW_REG_WRITE] = 1'b0;
                cw[CW_BRANCH]    = 1'b1;
                imm              = imm & 32'hffff_fffe;
            end
            12: begin
                cw[CW_JUMP]            = 1'b1;
                cw[CW_JUMP_REG]        = r[18];  // jalr or jal.
                cw[CW_WB_SEL_LSB +: 2] = WB_PC4;
            end
            13: cw[CW_WB_SEL_LSB +: 2] = WB_IMM;
            default: cw[CW_REG_WRITE] = 1'b0;
        endcase
        ctrl_word = cw;
    endtask

    initial begin
        #(3 * (MEM_WORDS + NUM_RANDOM) * 20);
        stop_with_failure("Timeout: the watchdog expired before all instructions were checked");
    end

    initial begin
        seed        = 32'h1596_5fe2;
        rst         = 1'b1;
        issue_valid = 1'b0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        imm         = '0;
        ctrl_word   = '0;
        br_cond     = BR_BEQ;
        rd          = '0;
        e_valid     = 1'b0;
        e_wait      = 1'b0;
        e_ctrl      = '0;
        @(posedge clk);
        repeat (3) begin
            @(negedge clk);
            check_level("stall_o in reset", stall, 1'b0);
            check_level("redirect_o in reset", redirect, 1'b0);
            check_level("wb_valid_o in reset", wb_valid, 1'b0);
        end
        @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            fill_word(i);  // every word gets a known value first.
            send_instr();
        end
        repeat (NUM_RANDOM) begin
            pick_instr();
            send_instr();
        end
        issue_valid = 1'b0;
        repeat (4) end_cycle();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- tb.f
common/rv32i_types.sv
common/pipe_ctrl_pkg.sv
common/ex_mem_if.sv
rtl/execute/ex_stage.sv
rtl/ex_mem.sv
rtl/memory/mem_stage.sv
rtl/pipe_ctrl.sv
rtl/rv32i_backend.sv
tb/rv32i_backend_chk.sv
tb/tb_rv32i_backend.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --top-module tb_rv32i_backend -f tb.f -o sim_tb &&
    ./obj_dir/sim_tb; } > sim.log 2>&1 || echo "Simulation finished: FAIL" >> sim.log
if grep -qF "Simulation finished: FAIL" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi
echo "PASS"
exit 0
